//--- led_matrix_top.f
+incdir+common
common/led_matrix_pkg.sv
src/uart_rx.sv
src/command_decoder.sv
src/framebuffer.sv
src/pixel_fetch.sv
matrix_scan/scan_fsm.sv
matrix_scan/bcm_timer.sv
src/led_matrix_top.sv
dv/led_matrix_properties.sv
dv/led_matrix_tb.sv

//--- Makefile
TOP := led_matrix_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f led_matrix_top.f \
		--top-module $(TOP) --Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir

//--- dv/led_matrix_tb.sv
`timescale 1ns/1ps
`include "led_matrix_defs.svh"

module led_matrix_tb import led_matrix_pkg::*; ();

    localparam int COLS        = `PIXEL_WIDTH;
    localparam int FRAME_BYTES = `PIXEL_WIDTH * `PIXEL_HEIGHT * `BYTES_PER_PIXEL;
    localparam int LATCH_LIMIT = 400; // cycles allowed per latch

    logic      clk_in = 1'b0;
    logic      rst_n;
    logic      rx;
    rgb_t      rgb1;
    rgb_t      rgb2;
    logic      clk_pixel;
    logic      row_latch;
    logic      output_enable;
    row_addr_t row_address;

    int seed = 32'h5e4b_6765;
    int value_errors;
    int timeout_errors;
    int checks;
    int planes_compared;

    pixel_t           model_fb [`PIXEL_WIDTH*`PIXEL_HEIGHT];
    brightness_mask_t model_bright;
    rgb_t             model_rgb;

    rgb_t      top_samples [COLS];
    rgb_t      bot_samples [COLS];
    int        n_samples;
    int        latch_count;
    int        lit_cycles;
    int        lit_plane;
    row_addr_t exp_row;
    plane_t    exp_plane;
    logic      tx_active; // a serial command is in flight
    logic      dirty;     // current plane may mix old and new state

    led_matrix_top DUT (.*);

    initial begin
        forever #10 clk_in = ~clk_in;
    end

    // plane bit of each channel, gated by both masks
    function automatic rgb_t expected_rgb(input pixel_t px, input int p);
        rgb_t v;
        v[0] = px[12 + p];
        v[1] = px[8 + p];
        v[2] = px[p];
        if (!model_bright[p]) v = 3'b000;
        return v & model_rgb;
    endfunction

    task automatic compare_plane();
        rgb_t e_top;
        rgb_t e_bot;
        for (int c = 0; c < COLS; c++) begin
            e_top = expected_rgb(model_fb[int'(exp_row) * COLS + c], int'(exp_plane));
            e_bot = expected_rgb(model_fb[(int'(exp_row) + `PIXEL_HALFHEIGHT) * COLS + c],
                                 int'(exp_plane));
            checks += 2;
            assert (top_samples[c] === e_top) else begin
                value_errors++;
                $display("** Error at %0t: rgb1 row %0d plane %0d col %0d got %b expected %b",
                         $time, exp_row, exp_plane, c, top_samples[c], e_top);
            end
            assert (bot_samples[c] === e_bot) else begin
                value_errors++;
                $display("** Error at %0t: rgb2 row %0d plane %0d col %0d got %b expected %b",
                         $time, exp_row, exp_plane, c, bot_samples[c], e_bot);
            end
        end
        planes_compared++;
    endtask

    // outputs sampled on the falling edge, away from register updates
    always @(negedge clk_in) begin
        if (!rst_n) begin
            assert (!clk_pixel && !row_latch && !output_enable) else begin
                value_errors++;
                $display("** Error at %0t: clk_pixel/row_latch/output_enable got %b%b%b expected 000",
                         $time, clk_pixel, row_latch, output_enable);
            end
        end else begin
            if (tx_active) dirty = 1'b1;
            assert (!(clk_pixel && output_enable)) else begin
                value_errors++;
                $display("pixel clock pulsed while the panel was lit at %0t", $time);
            end
            if (clk_pixel) begin
                if (n_samples < COLS) begin
                    top_samples[n_samples] = rgb1;
                    bot_samples[n_samples] = rgb2;
                end
                n_samples++;
            end
            if (output_enable) begin
                lit_cycles++;
            end else if (lit_cycles > 0) begin
                checks++;
                assert (lit_cycles == (`DISPLAY_BASE_TICKS << lit_plane)) else begin
                    value_errors++;
                    $display("** Error at %0t: output_enable plane %0d got %0d cycles expected %0d",
                             $time, lit_plane, lit_cycles, `DISPLAY_BASE_TICKS << lit_plane);
                end
                lit_cycles = 0;
            end
            if (row_latch) begin
                checks += 2;
                assert (row_address === exp_row) else begin
                    value_errors++;
                    $display("** Error at %0t: row_address got %0d expected %0d",
                             $time, row_address, exp_row);
                end
                assert (n_samples == COLS && !output_enable) else begin
                    value_errors++;
                    $display("latch after %0d pixel clocks or while lit at %0t", n_samples, $time);
                end
                if (!dirty) compare_plane();
                dirty     = tx_active;
                n_samples = 0;
                lit_plane = int'(exp_plane);
                if (exp_plane == plane_t'(`BRIGHTNESS_LEVELS - 1)) exp_row = exp_row + 1'b1;
                exp_plane = exp_plane + 1'b1;
                latch_count++;
            end
        end
    end

    task automatic send_byte(input logic [7:0] data);
        logic [9:0] frame;
        frame = {1'b1, data, 1'b0}; // stop, data, start
        for (int i = 0; i < 10; i++) begin
            rx <= frame[i];
            repeat (`TICKS_PER_BIT) @(posedge clk_in);
        end
    endtask

    task automatic load_frame();
        logic [7:0] data;
        tx_active = 1'b1;
        send_byte(`CMD_LOAD_FRAME);
        for (int a = 0; a < FRAME_BYTES; a++) begin
            data = 8'($random(seed));
            send_byte(data);
            if (a % 2 == 0) model_fb[a / 2][15:8] = data; // even byte is the upper half
            else model_fb[a / 2][7:0] = data;
        end
        tx_active = 1'b0;
    endtask

    task automatic send_command(input logic [7:0] cmd, input logic [7:0] arg);
        tx_active = 1'b1;
        send_byte(cmd);
        send_byte(arg);
        if (cmd == `CMD_SET_BRIGHTNESS) model_bright = arg[3:0];
        if (cmd == `CMD_SET_RGB) model_rgb = arg[2:0];
        tx_active = 1'b0;
    endtask

    task automatic send_noise(input int count);
        logic [7:0] data;
        tx_active = 1'b1;
        for (int i = 0; i < count; i++) begin
            data = 8'($random(seed));
            if (data >= `CMD_LOAD_FRAME && data <= `CMD_SET_RGB) data = data + 8'd4;
            send_byte(data);
        end
        tx_active = 1'b0;
    endtask

    task automatic wait_latches(input int count);
        int target;
        int cycles;
        target = latch_count + count;
        cycles = 0;
        while (latch_count < target && cycles < count * LATCH_LIMIT) begin
            @(posedge clk_in);
            cycles++;
        end
        assert (latch_count >= target) else begin
            timeout_errors++;
            $display("timeout: only %0d of %0d row latches seen", count - (target - latch_count),
                     count);
        end
    endtask

    initial begin
        logic [7:0] arg;
        rst_n           = 1'b0;
        rx              = 1'b1;
        tx_active       = 1'b0;
        dirty           = 1'b1; // framebuffer holds no frame yet
        value_errors    = 0;
        timeout_errors  = 0;
        checks          = 0;
        planes_compared = 0;
        n_samples       = 0;
        latch_count     = 0;
        lit_cycles      = 0;
        lit_plane       = 0;
        exp_row         = '0;
        exp_plane       = '0;
        model_bright    = '1;
        model_rgb       = '1;
        repeat (2) @(posedge clk_in);
        rst_n <= 1'b1;
        @(posedge clk_in);
        load_frame();
        wait_latches(32);
        arg = 8'($random(seed));
        if (arg[3:0] == 4'hf) arg[0] = 1'b0; // at least one plane off
        if (arg[3:0] == 4'h0) arg[3] = 1'b1; // and one still on
        send_command(`CMD_SET_BRIGHTNESS, arg);
        wait_latches(20);
        arg = 8'($random(seed));
        if (arg[2:0] == 3'b111) arg[1] = 1'b0;
        if (arg[2:0] == 3'b000) arg[2] = 1'b1;
        send_command(`CMD_SET_RGB, arg);
        send_noise(6);
        wait_latches(20);
        assert (planes_compared > 0) else begin
            value_errors++;
            $display("no plane was ever compared against the model");
        end
        $display("checks %0d, value errors %0d, timeout errors %0d, planes compared %0d",
                 checks, value_errors, timeout_errors, planes_compared);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- dv/led_matrix_properties.sv
`timescale 1ns/1ps

module led_matrix_properties (
    input logic clk_in,
    input logic rst_n,
    input logic clk_pixel,
    input logic row_latch,
    input logic output_enable
);

    // shifting and display never overlap
    pixel_clock_dark: assert property (@(posedge clk_in) disable iff (!rst_n)
        !(clk_pixel && output_enable))
        else $error("clk_pixel high while output_enable is high");

    latch_one_cycle: assert property (@(posedge clk_in) disable iff (!rst_n)
        row_latch |=> !row_latch)
        else $error("row_latch held longer than one cycle");

    latch_while_dark: assert property (@(posedge clk_in) disable iff (!rst_n)
        row_latch |-> !output_enable)
        else $error("row_latch while output_enable is high");

endmodule

bind led_matrix_top led_matrix_properties u_properties (
    .clk_in        (clk_in),
    .rst_n         (rst_n),
    .clk_pixel     (clk_pixel),
    .row_latch     (row_latch),
    .output_enable (output_enable)
);

//--- src/led_matrix_top.sv
`timescale 1ns/1ps

module led_matrix_top import led_matrix_pkg::*; (
    input  logic      clk_in,
    input  logic      rst_n,
    input  logic      rx,
    output rgb_t      rgb1, // top half
    output rgb_t      rgb2, // bottom half
    output logic      clk_pixel,
    output logic      row_latch,
    output logic      output_enable,
    output row_addr_t row_address
);

    logic [7:0]       rx_data;
    logic             rx_valid;
    logic             fb_wr_en;
    fb_byte_addr_t    fb_wr_addr;
    logic [7:0]       fb_wr_data;
    brightness_mask_t brightness_enable;
    rgb_t             rgb_enable;
    fb_word_addr_t    rd_addr;
    pixel_t           rd_data;
    logic             fetch_start;
    logic             fetch_done;
    col_addr_t        column;
    row_addr_t        row;
    plane_t           plane;
    logic             timer_start;
    logic             timer_done;

    uart_rx u_uart_rx (
        .clk_in   (clk_in),
        .rst_n    (rst_n),
        .rx       (rx),
        .rx_data  (rx_data),
        .rx_valid (rx_valid)
    );

    command_decoder u_command_decoder (
        .clk_in            (clk_in),
        .rst_n             (rst_n),
        .rx_data           (rx_data),
        .rx_valid          (rx_valid),
        .fb_wr_en          (fb_wr_en),
        .fb_wr_addr        (fb_wr_addr),
        .fb_wr_data        (fb_wr_data),
        .brightness_enable (brightness_enable),
        .rgb_enable        (rgb_enable)
    );

    framebuffer u_framebuffer (
        .clk_in  (clk_in),
        .wr_en   (fb_wr_en),
        .wr_addr (fb_wr_addr),
        .wr_data (fb_wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    pixel_fetch u_pixel_fetch (
        .clk_in            (clk_in),
        .rst_n             (rst_n),
        .fetch_start       (fetch_start),
        .column            (column),
        .row               (row),
        .plane             (plane),
        .brightness_enable (brightness_enable),
        .rgb_enable        (rgb_enable),
        .rd_addr           (rd_addr),
        .rd_data           (rd_data),
        .rgb_top           (rgb1),
        .rgb_bottom        (rgb2),
        .fetch_done        (fetch_done)
    );

    scan_fsm u_scan_fsm (
        .clk_in      (clk_in),
        .rst_n       (rst_n),
        .fetch_done  (fetch_done),
        .timer_done  (timer_done),
        .fetch_start (fetch_start),
        .column      (column),
        .row         (row),
        .plane       (plane),
        .timer_start (timer_start),
        .clk_pixel   (clk_pixel),
        .row_latch   (row_latch),
        .row_address (row_address)
    );

    bcm_timer u_bcm_timer (
        .clk_in        (clk_in),
        .rst_n         (rst_n),
        .timer_start   (timer_start),
        .plane         (plane),
        .output_enable (output_enable),
        .timer_done    (timer_done)
    );

endmodule

//--- matrix_scan/bcm_timer.sv
`timescale 1ns/1ps
`include "led_matrix_defs.svh"

module bcm_timer import led_matrix_pkg::*; (
    input  logic   clk_in,
    input  logic   rst_n,
    input  logic   timer_start,
    input  plane_t plane,
    output logic   output_enable,
    output logic   timer_done
);

    // wide enough for the longest plane minus one
    localparam int CW = $clog2(`DISPLAY_BASE_TICKS << (`BRIGHTNESS_LEVELS - 1));

    logic [CW-1:0] remaining;

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            output_enable <= 1'b0;
            remaining     <= '0;
        end else if (timer_start) begin
            output_enable <= 1'b1;
            remaining     <= CW'((`DISPLAY_BASE_TICKS << plane) - 1); // binary weight
        end else if (output_enable) begin
            if (remaining == '0) output_enable <= 1'b0;
            else remaining <= remaining - 1'b1;
        end
    end

    assign timer_done = output_enable && (remaining == '0); // last lit cycle

endmodule

//--- matrix_scan/scan_fsm.sv
`timescale 1ns/1ps
`include "led_matrix_defs.svh"

module scan_fsm import led_matrix_pkg::*; (
    input  logic      clk_in,
    input  logic      rst_n,
    input  logic      fetch_done,
    input  logic      timer_done,
    output logic      fetch_start,
    output col_addr_t column,
    output row_addr_t row,
    output plane_t    plane,
    output logic      timer_start,
    output logic      clk_pixel,
    output logic      row_latch,
    output row_addr_t row_address
);

    localparam plane_t PLANE_LAST = plane_t'(`BRIGHTNESS_LEVELS - 1);

    scan_state_t state;
    logic        kick; // first fetch after reset

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            kick <= 1'b1;
        end else begin
            kick <= 1'b0;
        end
    end

    // a fetch is issued one cycle ahead of FETCH so a column takes 5 cycles
    assign fetch_start = kick || (state == CLOCK_LOW && column != '0) ||
                         (state == DISPLAY && timer_done);
    assign clk_pixel   = (state == CLOCK_HIGH);
    assign row_latch   = (state == LATCH);
    assign timer_start = (state == LATCH); // display starts right after the latch

    // counters wrap naturally, the panel dimensions are powers of two
    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            state       <= FETCH;
            column      <= '0;
            row         <= '0;
            plane       <= '0;
            row_address <= '0;
        end else begin
            case (state)
                FETCH: if (fetch_done) state <= CLOCK_HIGH;
                CLOCK_HIGH: begin
                    column <= column + 1'b1;
                    state  <= CLOCK_LOW;
                end
                CLOCK_LOW: begin
                    if (column == '0) begin // all columns shifted
                        row_address <= row;
                        state       <= LATCH;
                    end else begin
                        state <= FETCH;
                    end
                end
                LATCH: begin
                    // advance early so the next fetch sees the new row and plane
                    plane <= plane + 1'b1;
                    if (plane == PLANE_LAST) row <= row + 1'b1;
                    state <= DISPLAY;
                end
                DISPLAY: if (timer_done) state <= FETCH;
                default: state <= FETCH;
            endcase
        end
    end

endmodule

//--- src/pixel_fetch.sv
`timescale 1ns/1ps
`include "led_matrix_defs.svh"

module pixel_fetch import led_matrix_pkg::*; (
    input  logic             clk_in,
    input  logic             rst_n,
    input  logic             fetch_start,
    input  col_addr_t        column,
    input  row_addr_t        row,
    input  plane_t           plane,
    input  brightness_mask_t brightness_enable,
    input  rgb_t             rgb_enable,
    output fb_word_addr_t    rd_addr,
    input  pixel_t           rd_data,
    output rgb_t             rgb_top,
    output rgb_t             rgb_bottom,
    output logic             fetch_done
);

    localparam int RED_LSB   = 12;
    localparam int GREEN_LSB = 8;
    localparam int BLUE_LSB  = 0;

    logic [1:0]    step; // 0 idle, 1 top word back, 2 bottom word back
    pixel_t        top_word;
    fb_word_addr_t top_addr;
    fb_word_addr_t bottom_addr;

    // current plane bit of each channel, then the two enable masks
    function automatic rgb_t plane_bits(pixel_t px, plane_t p, brightness_mask_t b_en,
                                        rgb_t c_en);
        rgb_t bits;
        bits[0] = px[RED_LSB + p];
        bits[1] = px[GREEN_LSB + p];
        bits[2] = px[BLUE_LSB + p];
        return b_en[p] ? (bits & c_en) : '0;
    endfunction

    assign top_addr    = fb_word_addr_t'(int'(row) * `PIXEL_WIDTH + int'(column));
    assign bottom_addr = fb_word_addr_t'((int'(row) + `PIXEL_HALFHEIGHT) * `PIXEL_WIDTH
                                         + int'(column));
    assign rd_addr     = (step == 2'd1) ? bottom_addr : top_addr;

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            step       <= 2'd0;
            fetch_done <= 1'b0;
            rgb_top    <= '0;
            rgb_bottom <= '0;
        end else begin
            fetch_done <= 1'b0;
            case (step)
                2'd0: if (fetch_start) step <= 2'd1; // top read issued this cycle
                2'd1: begin
                    top_word <= rd_data;
                    step     <= 2'd2;
                end
                2'd2: begin
                    rgb_top    <= plane_bits(top_word, plane, brightness_enable, rgb_enable);
                    rgb_bottom <= plane_bits(rd_data, plane, brightness_enable, rgb_enable);
                    fetch_done <= 1'b1; // third cycle after start
                    step       <= 2'd0;
                end
                default: step <= 2'd0;
            endcase
        end
    end

endmodule

//--- src/framebuffer.sv
`timescale 1ns/1ps
`include "led_matrix_defs.svh"

module framebuffer import led_matrix_pkg::*; (
    input  logic          clk_in,
    input  logic          wr_en,
    input  fb_byte_addr_t wr_addr,
    input  logic [7:0]    wr_data,
    input  fb_word_addr_t rd_addr,
    output pixel_t        rd_data
);

    localparam int WORDS = `PIXEL_WIDTH * `PIXEL_HEIGHT;

    // even bytes hold the upper half of each pixel word
    logic [7:0] upper_bank [WORDS];
    logic [7:0] lower_bank [WORDS];

    always_ff @(posedge clk_in) begin
        if (wr_en) begin
            if (wr_addr[0]) lower_bank[wr_addr[$bits(wr_addr)-1:1]] <= wr_data;
            else            upper_bank[wr_addr[$bits(wr_addr)-1:1]] <= wr_data;
        end
        rd_data <= {upper_bank[rd_addr], lower_bank[rd_addr]}; // one cycle latency
    end

endmodule

//--- src/command_decoder.sv
`timescale 1ns/1ps
`include "led_matrix_defs.svh"

module command_decoder import led_matrix_pkg::*; (
    input  logic             clk_in,
    input  logic             rst_n,
    input  logic [7:0]       rx_data,
    input  logic             rx_valid,
    output logic             fb_wr_en,
    output fb_byte_addr_t    fb_wr_addr,
    output logic [7:0]       fb_wr_data,
    output brightness_mask_t brightness_enable,
    output rgb_t             rgb_enable
);

    localparam int FRAME_BYTES = `PIXEL_WIDTH * `PIXEL_HEIGHT * `BYTES_PER_PIXEL;
    localparam fb_byte_addr_t LAST_BYTE = fb_byte_addr_t'(FRAME_BYTES - 1);

    cmd_state_t    state;
    fb_byte_addr_t byte_cnt;

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            state             <= IDLE;
            byte_cnt          <= '0;
            fb_wr_en          <= 1'b0;
            brightness_enable <= '1; // everything on after reset
            rgb_enable        <= '1;
        end else begin
            fb_wr_en <= 1'b0;
            if (rx_valid) begin
                case (state)
                    IDLE: begin
                        byte_cnt <= '0;
                        case (rx_data)
                            `CMD_LOAD_FRAME:     state <= LOAD;
                            `CMD_SET_BRIGHTNESS: state <= ARG_BRIGHTNESS;
                            `CMD_SET_RGB:        state <= ARG_RGB;
                            default:             state <= IDLE; // unknown byte dropped
                        endcase
                    end
                    LOAD: begin
                        fb_wr_en   <= 1'b1;
                        fb_wr_addr <= byte_cnt;
                        fb_wr_data <= rx_data;
                        byte_cnt   <= byte_cnt + 1'b1;
                        if (byte_cnt == LAST_BYTE) state <= IDLE;
                    end
                    ARG_BRIGHTNESS: begin
                        brightness_enable <= rx_data[`BRIGHTNESS_LEVELS-1:0];
                        state             <= IDLE;
                    end
                    ARG_RGB: begin
                        rgb_enable <= rx_data[2:0]; // r, g, b enables
                        state      <= IDLE;
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

endmodule

//--- src/uart_rx.sv
`timescale 1ns/1ps
`include "led_matrix_defs.svh"

module uart_rx (
    input  logic       clk_in,
    input  logic       rst_n,
    input  logic       rx,
    output logic [7:0] rx_data,
    output logic       rx_valid
);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    localparam int TW = $clog2(`TICKS_PER_BIT);
    localparam logic [TW-1:0] TICK_LAST = TW'(`TICKS_PER_BIT - 1);
    localparam logic [TW-1:0] TICK_HALF = TW'(`TICKS_PER_BIT / 2 - 1);

    logic          rx_meta;
    logic          rx_sync;
    rx_state_t     state;
    logic [TW-1:0] tick_cnt;
    logic [2:0]    bit_cnt;
    logic [7:0]    shreg;

    // two flops, line idles high
    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            state    <= RX_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    tick_cnt <= '0;
                    if (!rx_sync) state <= RX_START; // falling edge of start bit
                end
                RX_START: begin
                    if (tick_cnt == TICK_HALF) begin
                        tick_cnt <= '0;
                        bit_cnt  <= '0;
                        state    <= rx_sync ? RX_IDLE : RX_DATA; // glitch rejected
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (tick_cnt == TICK_LAST) begin
                        tick_cnt <= '0;
                        shreg    <= {rx_sync, shreg[7:1]}; // lsb first
                        bit_cnt  <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) state <= RX_STOP;
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (tick_cnt == TICK_LAST) begin
                        if (rx_sync) begin
                            rx_data  <= shreg;
                            rx_valid <= 1'b1;
                        end
                        state <= RX_IDLE; // framing error drops the byte
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

endmodule

//--- common/led_matrix_pkg.sv
`include "led_matrix_defs.svh"

package led_matrix_pkg;

    typedef logic [$clog2(`PIXEL_WIDTH)-1:0]      col_addr_t;
    typedef logic [$clog2(`PIXEL_HALFHEIGHT)-1:0] row_addr_t; // row within a half
    typedef logic [$clog2(`BRIGHTNESS_LEVELS)-1:0] plane_t;
    typedef logic [`BRIGHTNESS_LEVELS-1:0]        brightness_mask_t;
    typedef logic [2:0]                           rgb_t; // bit 0 red, 1 green, 2 blue

    // red 15:12, green 11:8, blue 3:0
    typedef logic [8*`BYTES_PER_PIXEL-1:0] pixel_t;

    typedef logic [$clog2(`PIXEL_WIDTH*`PIXEL_HEIGHT*`BYTES_PER_PIXEL)-1:0] fb_byte_addr_t;
    typedef logic [$clog2(`PIXEL_WIDTH*`PIXEL_HEIGHT)-1:0] fb_word_addr_t;

    typedef enum logic [1:0] {IDLE, LOAD, ARG_BRIGHTNESS, ARG_RGB} cmd_state_t;

    typedef enum logic [2:0] {FETCH, CLOCK_HIGH, CLOCK_LOW, LATCH, DISPLAY} scan_state_t;

endpackage

//--- common/led_matrix_defs.svh
`ifndef LED_MATRIX_DEFS_SVH
`define LED_MATRIX_DEFS_SVH

// panel geometry, two halves scanned together
`define PIXEL_WIDTH        16
`define PIXEL_HEIGHT       8
`define PIXEL_HALFHEIGHT   4
`define BYTES_PER_PIXEL    2
`define BRIGHTNESS_LEVELS  4 // bit planes per channel

`define TICKS_PER_BIT      8 // clk_in cycles per serial bit

// plane b is lit for DISPLAY_BASE_TICKS << b cycles
`define DISPLAY_BASE_TICKS 4

`define CMD_LOAD_FRAME     8'h01
`define CMD_SET_BRIGHTNESS 8'h02
`define CMD_SET_RGB        8'h03

`endif
